//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_self_attention_head
FILELIST  := self_attention_head.f
BUILD_DIR := obj_dir
LOG       := sim.log

SOURCES := $(filter-out +%,$(shell cat $(FILELIST))) attn_defines.svh
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM)
	-./$(SIM) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q '^>>> PASS$$' $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- attn_defines.svh
// Attention head sizes and widths
// Shared by the package and every block of the score path
`ifndef ATTN_DEFINES_SVH
`define ATTN_DEFINES_SVH

// Tokens per row and head dimension
`define ATTN_TOKENS 4
`define ATTN_DIM 4

// Scores per chunk out of the matmul
`define ATTN_CHUNK 2

// Key index width for the key write port
`define ATTN_IDX_W 2

// Rescale of raw products into Q3.4 scores
`define ATTN_SHIFT 4

// Operand, accumulator, score and probability widths
`define ATTN_OP_W 8
`define ATTN_ACC_W 18
`define ATTN_SCORE_W 8
`define ATTN_PROB_W 8

`endif

//--- attn_pkg.sv
// Attention head types
// Vectors, chunk structs and the softmax state encoding
`include "attn_defines.svh"

package attn_pkg;

    // Scalar words
    typedef logic signed [`ATTN_OP_W-1:0] op_t;
    typedef logic signed [`ATTN_ACC_W-1:0] acc_t;
    typedef logic signed [`ATTN_SCORE_W-1:0] score_t;
    typedef logic [`ATTN_PROB_W-1:0] prob_t;

    // Query row or key row
    typedef op_t [`ATTN_DIM-1:0] vec_t;

    // Raw dot products straight out of the matmul
    typedef struct packed {
        logic valid;
        logic last;
        acc_t [`ATTN_CHUNK-1:0] data;
    } raw_chunk_t;

    // Rescaled and saturated scores
    typedef struct packed {
        logic valid;
        logic last;
        score_t [`ATTN_CHUNK-1:0] data;
    } score_chunk_t;

    typedef score_t [`ATTN_TOKENS-1:0] score_row_t;
    typedef prob_t [`ATTN_TOKENS-1:0] prob_row_t;

    typedef enum logic [2:0] {
        SM_IDLE,
        SM_MAX,
        SM_EXP,
        SM_SUM,
        SM_DIV,
        SM_NORM
    } sm_state_t;

endpackage

//--- row_assembler.sv
// Block to row converter
// Places score chunks into consecutive slots of one row register
`include "attn_defines.svh"

module row_assembler (
    input  logic                    clk,
    input  logic                    rst_n,
    input  attn_pkg::score_chunk_t  chunk,
    output logic                    row_valid,
    output attn_pkg::score_row_t    row
);
    import attn_pkg::*;

    localparam int NCHUNK = `ATTN_TOKENS / `ATTN_CHUNK;
    localparam int SLOT_W = (NCHUNK > 1) ? $clog2(NCHUNK) : 1;
    localparam int LAST_SLOT = NCHUNK - 1;

    logic [SLOT_W-1:0] slot_q;
    logic              row_valid_q;
    score_row_t        row_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slot_q      <= '0;
            row_valid_q <= 1'b0;
        end else begin
            row_valid_q <= chunk.valid && chunk.last;
            if (chunk.valid) begin
                slot_q <= chunk.last ? '0 : slot_q + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (chunk.valid) begin
            for (int i = 0; i < `ATTN_CHUNK; i++) begin
                row_q[int'(slot_q) * `ATTN_CHUNK + i] <= chunk.data[i];
            end
        end
    end

    assign row_valid = row_valid_q;
    assign row       = row_q;

    // Upstream last flag must line up with the final slot
    a_last_at_final_slot: assert property (
        @(posedge clk) disable iff (!rst_n)
        chunk.valid |-> (chunk.last == (slot_q == SLOT_W'(LAST_SLOT)))
    );

endmodule

//--- score_matmul.sv
// Query times transposed key matrix
// Key rows in registers, all dot products in one stage, streamed out as chunks
`include "attn_defines.svh"

module score_matmul (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    k_valid,
    input  logic [`ATTN_IDX_W-1:0]  k_idx,
    input  attn_pkg::vec_t          k_row,
    input  logic                    q_valid,
    input  attn_pkg::vec_t          q_row,
    output attn_pkg::raw_chunk_t    chunk
);
    import attn_pkg::*;

    localparam int NCHUNK = `ATTN_TOKENS / `ATTN_CHUNK;
    localparam int SEL_W = (NCHUNK > 1) ? $clog2(NCHUNK) : 1;

    // Row j holds key j, i.e. column j of K transposed
    vec_t key_q [`ATTN_TOKENS];
    acc_t acc_q [`ATTN_TOKENS];

    logic             emit_q;
    logic [SEL_W-1:0] sel_q;
    logic             sel_last;

    function automatic acc_t dot(vec_t a, vec_t b);
        acc_t sum;
        sum = '0;
        for (int i = 0; i < `ATTN_DIM; i++) begin
            sum = sum + acc_t'($signed(a[i])) * acc_t'($signed(b[i]));
        end
        return sum;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int j = 0; j < `ATTN_TOKENS; j++) begin
                key_q[j] <= '0;
            end
        end else if (k_valid) begin
            key_q[k_idx] <= k_row;
        end
    end

    // All four products in parallel
    always_ff @(posedge clk) begin
        if (q_valid) begin
            for (int j = 0; j < `ATTN_TOKENS; j++) begin
                acc_q[j] <= dot(q_row, key_q[j]);
            end
        end
    end

    assign sel_last = (sel_q == SEL_W'(NCHUNK - 1));

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            emit_q <= 1'b0;
            sel_q  <= '0;
        end else if (q_valid) begin
            emit_q <= 1'b1;
            sel_q  <= '0;
        end else if (emit_q) begin
            if (sel_last) begin
                emit_q <= 1'b0;
            end
            sel_q <= sel_last ? '0 : sel_q + 1'b1;
        end
    end

    always_comb begin
        chunk.valid = emit_q;
        chunk.last  = emit_q && sel_last;
        for (int i = 0; i < `ATTN_CHUNK; i++) begin
            chunk.data[i] = acc_q[int'(sel_q) * `ATTN_CHUNK + i];
        end
    end

    // Throttle upstream must hold queries until the burst is out
    a_no_query_in_burst: assert property (
        @(posedge clk) disable iff (!rst_n) q_valid |-> !emit_q
    );

endmodule

//--- score_rshift.sv
// Score rescale stage
// Arithmetic right shift and saturation of each raw dot product
`include "attn_defines.svh"

module score_rshift (
    input  logic                    clk,
    input  logic                    rst_n,
    input  attn_pkg::raw_chunk_t    chunk_in,
    output attn_pkg::score_chunk_t  chunk_out
);
    import attn_pkg::*;

    localparam acc_t SAT_HI = acc_t'((1 << (`ATTN_SCORE_W - 1)) - 1);
    localparam acc_t SAT_LO = -acc_t'(1 << (`ATTN_SCORE_W - 1));

    logic                          valid_q;
    logic                          last_q;
    score_t [`ATTN_CHUNK-1:0]      data_q;

    function automatic score_t saturate(acc_t raw);
        acc_t   sh;
        score_t res;
        sh = raw >>> `ATTN_SHIFT;
        if (sh > SAT_HI) begin
            res = score_t'(SAT_HI);
        end else if (sh < SAT_LO) begin
            res = score_t'(SAT_LO);
        end else begin
            res = score_t'(sh);
        end
        return res;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= chunk_in.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (chunk_in.valid) begin
            last_q <= chunk_in.last;
            for (int i = 0; i < `ATTN_CHUNK; i++) begin
                data_q[i] <= saturate(chunk_in.data[i]);
            end
        end
    end

    assign chunk_out.valid = valid_q;
    assign chunk_out.last  = last_q;
    assign chunk_out.data  = data_q;

endmodule

//--- self_attention_head.f
+incdir+.
attn_pkg.sv
score_matmul.sv
score_rshift.sv
row_assembler.sv
softmax_row.sv
self_attention_head.sv
tb_self_attention_head.sv

//--- self_attention_head.sv
// Score path of one self-attention head
// Q x K^T, rescale, block to row and softmax with a one-row in_ready throttle
`include "attn_defines.svh"

module self_attention_head (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    k_valid,
    input  logic [`ATTN_IDX_W-1:0]  k_idx,
    input  attn_pkg::vec_t          k_row,
    input  logic                    q_valid,
    input  attn_pkg::vec_t          q_row,
    output logic                    in_ready,
    output logic                    prob_valid,
    output attn_pkg::prob_row_t     prob_row
);
    import attn_pkg::*;

    logic         busy_q;
    logic         q_accept;
    raw_chunk_t   raw_chunk;
    score_chunk_t score_chunk;
    logic         row_valid;
    score_row_t   score_row;

    // Queries offered while busy are dropped here
    assign q_accept = q_valid && !busy_q;
    assign in_ready = !busy_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else if (q_accept) begin
            busy_q <= 1'b1;
        end else if (prob_valid) begin
            busy_q <= 1'b0;
        end
    end

    score_matmul matmul_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .k_valid (k_valid),
        .k_idx   (k_idx),
        .k_row   (k_row),
        .q_valid (q_accept),
        .q_row   (q_row),
        .chunk   (raw_chunk)
    );

    score_rshift rshift_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .chunk_in  (raw_chunk),
        .chunk_out (score_chunk)
    );

    row_assembler b2r_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .chunk     (score_chunk),
        .row_valid (row_valid),
        .row       (score_row)
    );

    softmax_row softmax_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .row_valid  (row_valid),
        .row        (score_row),
        .prob_valid (prob_valid),
        .prob_row   (prob_row)
    );

endmodule

//--- softmax_row.sv
// Fixed-point softmax over one score row
// Max, base-2 exponent table, sum, restoring reciprocal and normalisation
`include "attn_defines.svh"

module softmax_row (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    row_valid,
    input  attn_pkg::score_row_t    row,
    output logic                    prob_valid,
    output attn_pkg::prob_row_t     prob_row
);
    import attn_pkg::*;

    localparam int EXP_W = 8;
    localparam int LUT_BITS = 4;
    localparam int DIFF_W = `ATTN_SCORE_W + 1;
    localparam int SUM_W = EXP_W + $clog2(`ATTN_TOKENS);
    localparam int DIV_W = 17;
    localparam int STEP_W = $clog2(DIV_W);
    localparam logic [DIV_W-1:0] DIVIDEND = DIV_W'(16'hffff);

    // round(255 * 2^(-f/16))
    localparam logic [EXP_W-1:0] EXP_LUT [2**LUT_BITS] = '{
        8'd255, 8'd244, 8'd234, 8'd224, 8'd214, 8'd205, 8'd197, 8'd188,
        8'd180, 8'd173, 8'd165, 8'd158, 8'd152, 8'd145, 8'd139, 8'd133
    };

    sm_state_t         state_q;
    logic [STEP_W-1:0] step_q;
    logic              prob_valid_q;

    score_row_t        score_q;
    score_t            max_q;
    logic [EXP_W-1:0]  e_q [`ATTN_TOKENS];
    logic [SUM_W-1:0]  sum_q;
    logic [SUM_W-1:0]  rem_q;
    logic [DIV_W-1:0]  quot_q;
    prob_row_t         prob_q;

    logic [SUM_W-1:0]  e_sum;
    logic [SUM_W:0]    trial;
    logic              div_bit;

    function automatic score_t row_max(score_row_t r);
        score_t m;
        m = r[0];
        for (int i = 1; i < `ATTN_TOKENS; i++) begin
            if ($signed(r[i]) > m) begin
                m = r[i];
            end
        end
        return m;
    endfunction

    // d = m - s stays within 0..255 for 8-bit scores
    function automatic logic [EXP_W-1:0] exp_of(score_t m, score_t s);
        logic signed [DIFF_W-1:0]       diff;
        logic [`ATTN_SCORE_W-1:0]       d;
        diff = DIFF_W'(m) - DIFF_W'(s);
        d = diff[`ATTN_SCORE_W-1:0];
        return EXP_LUT[d[LUT_BITS-1:0]] >> d[`ATTN_SCORE_W-1:LUT_BITS];
    endfunction

    always_comb begin
        e_sum = '0;
        for (int i = 0; i < `ATTN_TOKENS; i++) begin
            e_sum = e_sum + SUM_W'(e_q[i]);
        end
    end

    // One restoring step per cycle, dividend bits shifted in from quot_q
    assign trial   = {rem_q, quot_q[DIV_W-1]};
    assign div_bit = (trial >= {1'b0, sum_q});

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q      <= SM_IDLE;
            step_q       <= '0;
            prob_valid_q <= 1'b0;
        end else begin
            prob_valid_q <= 1'b0;
            case (state_q)
                SM_IDLE: begin
                    if (row_valid) begin
                        state_q <= SM_MAX;
                    end
                end
                SM_MAX:  state_q <= SM_EXP;
                SM_EXP:  state_q <= SM_SUM;
                SM_SUM: begin
                    state_q <= SM_DIV;
                    step_q  <= '0;
                end
                SM_DIV: begin
                    if (step_q == STEP_W'(DIV_W - 1)) begin
                        state_q <= SM_NORM;
                    end
                    step_q <= step_q + 1'b1;
                end
                SM_NORM: begin
                    state_q      <= SM_IDLE;
                    prob_valid_q <= 1'b1;
                end
                default: state_q <= SM_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (state_q)
            SM_IDLE: begin
                if (row_valid) begin
                    score_q <= row;
                end
            end
            SM_MAX: max_q <= row_max(score_q);
            SM_EXP: begin
                for (int i = 0; i < `ATTN_TOKENS; i++) begin
                    e_q[i] <= exp_of(max_q, score_q[i]);
                end
            end
            SM_SUM: begin
                sum_q  <= e_sum;
                rem_q  <= '0;
                quot_q <= DIVIDEND;
            end
            SM_DIV: begin
                rem_q  <= div_bit ? SUM_W'(trial - {1'b0, sum_q}) : trial[SUM_W-1:0];
                quot_q <= {quot_q[DIV_W-2:0], div_bit};
            end
            SM_NORM: begin
                for (int i = 0; i < `ATTN_TOKENS; i++) begin
                    prob_q[i] <= prob_t'((32'(e_q[i]) * 32'(quot_q)) >> `ATTN_PROB_W);
                end
            end
            default: ;
        endcase
    end

    assign prob_valid = prob_valid_q;
    assign prob_row   = prob_q;

    // Only one row in flight, enforced by the in_ready throttle at the top
    a_row_only_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) row_valid |-> state_q == SM_IDLE
    );

endmodule

//--- tb_self_attention_head.sv
// Testbench for the self-attention score path
// Loads keys, sends queries and checks latency and probabilities against a model
`include "attn_defines.svh"

module tb_self_attention_head;
    import attn_pkg::*;

    localparam int LATENCY = 26;
    localparam int NUM_QUERIES = 56;
    localparam int TIMEOUT_CYCLES = 40 * NUM_QUERIES + 200;

    logic                   clk;
    logic                   rst_n;
    logic                   k_valid;
    logic [`ATTN_IDX_W-1:0] k_idx;
    vec_t                   k_row;
    logic                   q_valid;
    vec_t                   q_row;
    logic                   in_ready;
    logic                   prob_valid;
    prob_row_t              prob_row;

    vec_t        keys [`ATTN_TOKENS];
    prob_row_t   expected_row;
    string       test_name;
    logic [31:0] seed;
    int          value_errors;
    int          protocol_errors;
    int          cycle_count;
    int          sent;
    logic        in_flight;
    int          age;
    int          accepted;
    int          pulses;

    // round(255 * 2^(-f/16))
    int exp_table [16] = '{255, 244, 234, 224, 214, 205, 197, 188,
                           180, 173, 165, 158, 152, 145, 139, 133};

    self_attention_head dut_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .k_valid    (k_valid),
        .k_idx      (k_idx),
        .k_row      (k_row),
        .q_valid    (q_valid),
        .q_row      (q_row),
        .in_ready   (in_ready),
        .prob_valid (prob_valid),
        .prob_row   (prob_row)
    );

    always #50 clk = ~clk;

    function automatic logic [31:0] lcg_next();
        seed = seed * 32'd1664525 + 32'd1013904223;
        return seed;
    endfunction

    function automatic vec_t random_vec();
        vec_t v;
        for (int i = 0; i < `ATTN_DIM; i++) begin
            v[i] = op_t'(lcg_next() >> 24);
        end
        return v;
    endfunction

    function automatic vec_t splat(input int x);
        vec_t v;
        for (int i = 0; i < `ATTN_DIM; i++) begin
            v[i] = op_t'(x);
        end
        return v;
    endfunction

    // Scores, shift and saturate, then base-2 softmax with a reciprocal
    function automatic prob_row_t model_row(input vec_t q);
        int        s [`ATTN_TOKENS];
        int        e [`ATTN_TOKENS];
        int        raw;
        int        m;
        int        d;
        int        sum;
        int        recip;
        prob_row_t p;
        for (int j = 0; j < `ATTN_TOKENS; j++) begin
            raw = 0;
            for (int i = 0; i < `ATTN_DIM; i++) begin
                raw = raw + int'(q[i]) * int'(keys[j][i]);
            end
            raw = raw >>> `ATTN_SHIFT;
            s[j] = (raw > 127) ? 127 : ((raw < -128) ? -128 : raw);
        end
        m = s[0];
        for (int j = 1; j < `ATTN_TOKENS; j++) begin
            m = (s[j] > m) ? s[j] : m;
        end
        sum = 0;
        for (int j = 0; j < `ATTN_TOKENS; j++) begin
            d = m - s[j];
            d = (d > 255) ? 255 : d;
            e[j] = exp_table[d % 16] >> (d / 16);
            sum = sum + e[j];
        end
        recip = 65535 / sum;
        for (int j = 0; j < `ATTN_TOKENS; j++) begin
            p[j] = prob_t'((e[j] * recip) >> 8);
        end
        return p;
    endfunction

    task automatic report_row_mismatch();
        for (int i = 0; i < `ATTN_TOKENS; i++) begin
            if (prob_row[i] !== expected_row[i]) begin
                value_errors++;
                $display("CHECK FAILED %s prob[%0d] expected %0d actual %0d",
                         test_name, i, expected_row[i], prob_row[i]);
            end
        end
    endtask

    task automatic report_protocol(input string what);
        protocol_errors++;
        $display("Protocol error in %s: %s", test_name, what);
    endtask

    task automatic write_keys();
        for (int j = 0; j < `ATTN_TOKENS; j++) begin
            @(negedge clk);
            k_valid = 1'b1;
            k_idx   = `ATTN_IDX_W'(j);
            k_row   = keys[j];
        end
        @(negedge clk);
        k_valid = 1'b0;
    endtask

    // Extra offers arrive while busy and must be dropped
    task automatic send_query(input vec_t q, input string name, input int extra_offers);
        @(negedge clk);
        while (!in_ready) begin
            @(negedge clk);
        end
        test_name    = name;
        expected_row = model_row(q);
        q_valid      = 1'b1;
        q_row        = q;
        sent++;
        @(negedge clk);
        q_valid = 1'b0;
        for (int n = 0; n < extra_offers; n++) begin
            q_valid = 1'b1;
            q_row   = random_vec();
            @(negedge clk);
        end
        q_valid = 1'b0;
        while (!prob_valid) begin
            @(negedge clk);
        end
    endtask

    // Tracks the accepted row and its age in cycles
    always @(posedge clk) begin
        if (!rst_n) begin
            in_flight <= 1'b0;
            age       <= 0;
            accepted  <= 0;
            pulses    <= 0;
        end else begin
            if (prob_valid) begin
                pulses <= pulses + 1;
            end
            if (q_valid && in_ready) begin
                in_flight <= 1'b1;
                age       <= 1;
                accepted  <= accepted + 1;
            end else if (in_flight) begin
                age <= age + 1;
                if (prob_valid) begin
                    in_flight <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display(">>> FAIL");
            $finish;
        end
    end

    a_reset_state: assert property (
        @(posedge clk) !rst_n |=> (in_ready && !prob_valid)
    ) else report_protocol("in_ready low or prob_valid high right after reset");

    a_latency: assert property (
        @(posedge clk) disable iff (!rst_n) prob_valid |-> (in_flight && age == LATENCY)
    ) else report_protocol("prob_valid did not come exactly 26 cycles after the query");

    a_prob_due: assert property (
        @(posedge clk) disable iff (!rst_n) (in_flight && age == LATENCY) |-> prob_valid
    ) else report_protocol("prob_valid missing 26 cycles after the query");

    a_busy_low: assert property (
        @(posedge clk) disable iff (!rst_n) in_flight |-> !in_ready
    ) else report_protocol("in_ready high while a row was in flight");

    a_ready_after: assert property (
        @(posedge clk) disable iff (!rst_n) prob_valid |=> in_ready
    ) else report_protocol("in_ready did not return after prob_valid");

    a_no_extra_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) prob_valid |-> (pulses < accepted)
    ) else report_protocol("prob_valid pulse without an accepted query");

    a_prob_row: assert property (
        @(posedge clk) disable iff (!rst_n) prob_valid |-> (prob_row == expected_row)
    ) else report_row_mismatch();

    initial begin
        clk             = 1'b0;
        rst_n           = 1'b0;
        k_valid         = 1'b0;
        k_idx           = '0;
        k_row           = '0;
        q_valid         = 1'b0;
        q_row           = '0;
        seed            = 32'hbc44_18ba;
        value_errors    = 0;
        protocol_errors = 0;
        cycle_count     = 0;
        sent            = 0;
        test_name       = "reset";
        expected_row    = '0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // Equal keys give equal scores
        for (int j = 0; j < `ATTN_TOKENS; j++) begin
            keys[j] = '{op_t'(10), op_t'(-20), op_t'(5), op_t'(3)};
        end
        write_keys();
        send_query(random_vec(), "equal_keys_a", 0);
        send_query(random_vec(), "equal_keys_b", 0);

        // Both saturation limits
        keys[0] = splat(127);
        keys[1] = splat(-127);
        keys[2] = '{op_t'(127), op_t'(-127), op_t'(127), op_t'(-127)};
        keys[3] = splat(0);
        write_keys();
        send_query(splat(127), "saturate_pos", 0);
        send_query(splat(-127), "saturate_neg", 0);

        // One dominant key, the rest far below it
        keys[0] = splat(127);
        keys[1] = '{op_t'(0), op_t'(0), op_t'(0), op_t'(-1)};
        keys[2] = splat(-10);
        keys[3] = splat(-127);
        write_keys();
        send_query(splat(64), "dominant", 0);

        for (int n = 0; n < 50; n++) begin
            for (int j = 0; j < `ATTN_TOKENS; j++) begin
                keys[j] = random_vec();
            end
            write_keys();
            send_query(random_vec(), $sformatf("random_%0d", n), 0);
        end

        send_query(random_vec(), "offer_while_busy", 3);
        repeat (4) @(negedge clk);

        test_name = "pulse_count";
        a_pulse_count: assert (pulses == accepted && accepted == sent)
        else report_protocol($sformatf("%0d queries sent, %0d accepted, %0d prob_valid pulses",
                                       sent, accepted, pulses));

        $display("Errors: %0d value, %0d protocol", value_errors, protocol_errors);
        if (value_errors == 0 && protocol_errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
